// ==== Bender.yml ====
package:
  name: enc_if

dependencies: {}

sources:
  # packages first, then the chain from pins to bus
  - src/enc_pkg.sv
  - src/wb_pkg.sv
  - src/enc_input_sync.sv
  - src/enc_quad_decoder.sv
  - src/enc_period_meter.sv
  - src/enc_wb_regs.sv
  - src/enc_if_top.sv

  # testbench, simulation only
  - target: simulation
    files:
      - verification/enc_if_tb.sv

// ==== flist.f ====
src/enc_pkg.sv
src/wb_pkg.sv
src/enc_input_sync.sv
src/enc_quad_decoder.sv
src/enc_period_meter.sv
src/enc_wb_regs.sv
src/enc_if_top.sv
verification/enc_if_tb.sv

// ==== src/enc_if_top.sv ====
`timescale 1ns/1ps

module enc_if_top (
   input  logic clk_fast,
   input  logic reset,
   input  logic a,
   input  logic b,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [wb_pkg::wb_addr_width-1:0] wb_adr,
   input  logic [wb_pkg::wb_data_width-1:0] wb_dat_w,
   output logic [wb_pkg::wb_data_width-1:0] wb_dat_r,
   output logic wb_ack
);

   import enc_pkg::*;

   logic a_s;                                   // synchronized lines
   logic b_s;
   logic tick;                                  // one cycle per edge
   logic dir;
   logic quad_error_pulse;
   logic signed [position_width-1:0] position;
   logic dir_invert;                            // from ctrl register
   logic pos_load;                              // preset strobe
   logic [position_width-1:0] pos_load_value;
   period_word_t period;

   // ----------------------------------------
   // pins -> decoder -> period -> bus
   // ----------------------------------------

   enc_input_sync enc_input_sync_i (
      .clk_fast (clk_fast),
      .reset    (reset),
      .a        (a),
      .b        (b),
      .a_s      (a_s),
      .b_s      (b_s)
   );

   enc_quad_decoder enc_quad_decoder_i (
      .clk_fast         (clk_fast),
      .reset            (reset),
      .a_s              (a_s),
      .b_s              (b_s),
      .dir_invert       (dir_invert),
      .pos_load         (pos_load),
      .pos_load_value   (pos_load_value),
      .tick             (tick),
      .dir              (dir),
      .quad_error_pulse (quad_error_pulse),
      .position         (position)
   );

   enc_period_meter enc_period_meter_i (
      .clk_fast (clk_fast),
      .reset    (reset),
      .tick     (tick),
      .dir      (dir),
      .period   (period)
   );

   enc_wb_regs enc_wb_regs_i (
      .clk_fast         (clk_fast),
      .reset            (reset),
      .wb_cyc           (wb_cyc),
      .wb_stb           (wb_stb),
      .wb_we            (wb_we),
      .wb_adr           (wb_adr),
      .wb_dat_w         (wb_dat_w),
      .wb_dat_r         (wb_dat_r),
      .wb_ack           (wb_ack),
      .period           (period),
      .position         (position),
      .quad_error_pulse (quad_error_pulse),
      .dir_invert       (dir_invert),
      .pos_load         (pos_load),
      .pos_load_value   (pos_load_value)
   );

endmodule

// ==== src/enc_input_sync.sv ====
`timescale 1ns/1ps

module enc_input_sync (
   input  logic clk_fast,
   input  logic reset,
   input  logic a,
   input  logic b,
   output logic a_s,
   output logic b_s
);

   // bit 1 carries a, bit 0 carries b
   logic [1:0] meta;                  // first flop, may go metastable
   logic [1:0] stable;                // second flop, settled
   logic [1:0] held;                  // clean copy for the decoder

   // ----------------------------------------
   // three fixed stages per line
   // ----------------------------------------

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         meta   <= 2'b00;
         stable <= 2'b00;
         held   <= 2'b00;
      end else begin
         meta   <= {a, b};            // async pins sampled here
         stable <= meta;              // resolve metastability
         held   <= stable;            // one more stage, glitch free
      end
   end

   assign a_s = held[1];
   assign b_s = held[0];

endmodule

// ==== src/enc_period_meter.sv ====
`timescale 1ns/1ps

module enc_period_meter (
   input  logic clk_fast,
   input  logic reset,
   input  logic tick,
   input  logic dir,
   output enc_pkg::period_word_t period
);

   import enc_pkg::*;

   logic [period_count_width-1:0] counter;  // cycles since last tick
   logic [period_count_width-1:0] latch;    // count at last tick
   logic dir_q;                             // dir, one cycle behind the tick
   logic dir_prev;                          // dir_q one cycle earlier
   logic dir_flip;                          // reversal seen this cycle
   logic dir_changed;                       // held until next tick
   period_word_t next_word;

   // dir moves on the same edge as tick, so it is retimed by one cycle
   // and the reversal lands after the tick has cleared the counter
   assign dir_flip = dir_q ^ dir_prev;

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         dir_q    <= 1'b0;
         dir_prev <= 1'b0;
      end else begin
         dir_q    <= dir;
         dir_prev <= dir_q;
      end
   end

   // ----------------------------------------
   // latch and saturating counter
   // ----------------------------------------

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         latch <= '0;
      end else if (tick) begin
         latch <= counter;            // value before the clear
      end
   end

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         counter     <= '0;
         dir_changed <= 1'b0;
      end else if (tick) begin
         counter     <= '0;           // restart, G cycles later reads G-1
         dir_changed <= 1'b0;
      end else if (dir_flip) begin
         counter     <= period_overflow; // reversal, period meaningless
         dir_changed <= 1'b1;
      end else if (counter != period_overflow) begin
         counter     <= counter + 1'b1;  // stops at overflow
      end
   end

   // ----------------------------------------
   // output word, larger of the two counts
   // ----------------------------------------

   always_comb begin
      next_word                    = '0;   // reserved bits read zero
      next_word.fields.dir         = dir_q;
      next_word.fields.dir_changed = dir_changed;
      if (counter >= latch) begin
         next_word.fields.from_latch = 1'b0; // running count is longer
         next_word.fields.count      = counter;
      end else begin
         next_word.fields.from_latch = 1'b1;
         next_word.fields.count      = latch;
      end
   end

   always_ff @(posedge clk_fast) begin
      period <= next_word;            // one cycle after the counter
   end

endmodule

// ==== src/enc_pkg.sv ====
// ----------------------------------------
// encoder constants
// ----------------------------------------

package enc_pkg;

   localparam int period_count_width = 22;                    // period counter bits
   localparam logic [period_count_width-1:0] period_overflow = '1; // saturated count

   localparam int position_width = 32;                        // signed position bits

   localparam int period_word_width = 32;                     // host word size
   localparam int period_flag_width = 3;                      // from_latch, dir, dir_changed
   localparam int period_reserved_width =
      period_word_width - period_flag_width - period_count_width; // 7 spare bits

   // ----------------------------------------
   // period word, raw and field views
   // ----------------------------------------

   typedef union packed {
      logic [period_word_width-1:0] raw;                      // as the host sees it
      struct packed {
         logic from_latch;                                    // latched value reported
         logic dir;                                           // current direction
         logic dir_changed;                                   // reversal since last tick
         logic [period_reserved_width-1:0] reserved;          // always zero
         logic [period_count_width-1:0] count;                // clk_fast cycles
      } fields;
   } period_word_t;

endpackage

// ==== src/enc_quad_decoder.sv ====
`timescale 1ns/1ps

module enc_quad_decoder (
   input  logic clk_fast,
   input  logic reset,
   input  logic a_s,
   input  logic b_s,
   input  logic dir_invert,
   input  logic pos_load,
   input  logic [enc_pkg::position_width-1:0] pos_load_value,
   output logic tick,
   output logic dir,
   output logic quad_error_pulse,
   output logic signed [enc_pkg::position_width-1:0] position
);

   import enc_pkg::*;

   logic a_prev;                      // a_s one cycle ago
   logic b_prev;                      // b_s one cycle ago
   logic a_changed;
   logic b_changed;
   logic one_step;                    // legal 4x transition
   logic both_step;                   // illegal, both lines moved
   logic step_dir;                    // 1 counts up
   logic signed [position_width-1:0] step; // +1 or -1

   // ----------------------------------------
   // transition detect
   // ----------------------------------------

   assign a_changed = a_s ^ a_prev;
   assign b_changed = b_s ^ b_prev;
   assign one_step  = a_changed ^ b_changed;   // exactly one line
   assign both_step = a_changed & b_changed;

   // new a against old b gives the phase order
   assign step_dir = (a_s ^ b_prev) ^ dir_invert;
   assign step     = step_dir ? position_width'(signed'(1)) : '1; // '1 is -1

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         a_prev <= 1'b0;              // matches sync reset value
         b_prev <= 1'b0;
      end else begin
         a_prev <= a_s;
         b_prev <= b_s;
      end
   end

   // ----------------------------------------
   // tick, direction, position
   // ----------------------------------------

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         tick             <= 1'b0;
         dir              <= 1'b0;
         quad_error_pulse <= 1'b0;
         position         <= '0;
      end else begin
         tick             <= one_step;   // one cycle after the change
         quad_error_pulse <= both_step;  // position and dir left alone
         if (one_step) begin
            dir <= step_dir;
         end
         if (pos_load) begin
            position <= signed'(pos_load_value); // preset wins over a step
         end else if (one_step) begin
            position <= position + step;
         end
      end
   end

endmodule

// ==== src/enc_wb_regs.sv ====
`timescale 1ns/1ps

module enc_wb_regs (
   input  logic clk_fast,
   input  logic reset,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [wb_pkg::wb_addr_width-1:0] wb_adr,
   input  logic [wb_pkg::wb_data_width-1:0] wb_dat_w,
   output logic [wb_pkg::wb_data_width-1:0] wb_dat_r,
   output logic wb_ack,
   input  enc_pkg::period_word_t period,
   input  logic signed [enc_pkg::position_width-1:0] position,
   input  logic quad_error_pulse,
   output logic dir_invert,
   output logic pos_load,
   output logic [enc_pkg::position_width-1:0] pos_load_value
);

   import wb_pkg::*;

   logic request;                     // cyc and stb both high
   logic access;                      // request not yet acked
   logic write_stb;                   // write lands this edge
   logic status_clear;                // host clears quad_error
   logic quad_error;                  // sticky error bit
   logic [wb_data_width-1:0] read_mux;

   // ----------------------------------------
   // classic handshake
   // ----------------------------------------

   assign request   = wb_cyc & wb_stb;
   assign access    = request & ~wb_ack;   // master drops stb after ack
   assign write_stb = access & wb_we;

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;            // exactly one cycle, no stall
      end
   end

   // ----------------------------------------
   // control and status
   // ----------------------------------------

   assign status_clear = write_stb & (wb_adr == reg_status_addr) &
                         wb_dat_w[status_quad_error_bit];

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         dir_invert <= 1'b0;
         quad_error <= 1'b0;
      end else begin
         if (write_stb && (wb_adr == reg_ctrl_addr)) begin
            dir_invert <= wb_dat_w[ctrl_dir_invert_bit];
         end
         if (quad_error_pulse) begin
            quad_error <= 1'b1;       // new error beats a clear
         end else if (status_clear) begin
            quad_error <= 1'b0;
         end
      end
   end

   // preset goes straight to the decoder, loads at the ack edge
   assign pos_load       = write_stb & (wb_adr == reg_position_addr);
   assign pos_load_value = wb_dat_w;

   // ----------------------------------------
   // read path
   // ----------------------------------------

   always_comb begin
      case (wb_adr)
         reg_period_addr:   read_mux = period.raw;
         reg_position_addr: read_mux = unsigned'(position);
         reg_ctrl_addr: begin
            read_mux = '0;
            read_mux[ctrl_dir_invert_bit] = dir_invert;
         end
         reg_status_addr: begin
            read_mux = '0;
            read_mux[status_quad_error_bit] = quad_error;
         end
         default:           read_mux = '0;   // unmapped reads zero
      endcase
   end

   always_ff @(posedge clk_fast) begin
      if (access) begin
         wb_dat_r <= read_mux;        // held while ack is high
      end
   end

endmodule

// ==== src/wb_pkg.sv ====
// ----------------------------------------
// bus widths and register map
// ----------------------------------------

package wb_pkg;

   localparam int wb_addr_width = 4;                          // word address
   localparam int wb_data_width = 32;                         // whole words only

   // word addresses
   localparam logic [wb_addr_width-1:0] reg_period_addr   = 0; // read only
   localparam logic [wb_addr_width-1:0] reg_position_addr = 1; // write presets position
   localparam logic [wb_addr_width-1:0] reg_ctrl_addr     = 2; // control bits
   localparam logic [wb_addr_width-1:0] reg_status_addr   = 3; // sticky status

   // bit positions inside ctrl and status
   localparam int ctrl_dir_invert_bit   = 0;                  // flips counting direction
   localparam int status_quad_error_bit = 0;                  // write 1 to clear

endpackage

// ==== verification/enc_if_tb.sv ====
`timescale 1ns/1ps

module enc_if_tb;

   import enc_pkg::*;
   import wb_pkg::*;

   localparam int clk_period   = 40;                   // ns
   localparam int num_steps    = 30;                   // random steps drawn up front
   localparam int walk_steps   = 25;                   // odd so a walk never nets zero
   localparam int settle       = 8;                    // pin to position is 4 cycles
   localparam int period_gap   = 40;                   // steady gap for period checks
   localparam int bus_op_limit = 40;                   // upper bound on bus transfers
   localparam int long_pause   = (1 << period_count_width) + 20; // past saturation

   logic clk_fast;
   logic reset;
   logic a;
   logic b;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [wb_addr_width-1:0] wb_adr;
   logic [wb_data_width-1:0] wb_dat_w;
   logic [wb_data_width-1:0] wb_dat_r;
   logic wb_ack;

   logic [31:0] rng_state;
   int gaps [num_steps];                               // cycles between pin edges
   bit forward [num_steps];                            // step direction
   logic signed [31:0] model_pos;                      // expected position
   logic model_dir;
   logic model_invert;                                 // mirrors ctrl bit 0
   logic ack_expected = 1'b0;
   longint watchdog_cycles;

   enc_if_top enc_if_top_i (
      .clk_fast (clk_fast),
      .reset    (reset),
      .a        (a),
      .b        (b),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   initial begin
      clk_fast = 1'b0;
      forever #(clk_period / 2) clk_fast = ~clk_fast;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;    // numerical recipes constants
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
         else stop_on_error($sformatf("ERR %s expected %h actual %h", test, expected, actual));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk_fast);
   endtask

   // one classic transfer, ack awaited with a short limit
   task automatic bus_cycle(input logic write, input logic [wb_addr_width-1:0] adr,
                            input logic [31:0] data_w, output logic [31:0] data_r);
      int waited;
      waited = 0;
      @(negedge clk_fast);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = write;
      wb_adr   = adr;
      wb_dat_w = data_w;
      do begin
         @(negedge clk_fast);
         waited++;
         if (waited > 4) begin
            stop_on_error($sformatf("no wb_ack for the request at address %0d", adr));
         end
      end while (wb_ack !== 1'b1);
      data_r = wb_dat_r;                               // valid while ack is high
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [wb_addr_width-1:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic bus_read(input logic [wb_addr_width-1:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 32'd0, data);
   endtask

   // legal 4x step, model follows new a against old b
   task automatic encoder_step(input bit fwd);
      logic new_a;
      logic new_b;
      @(negedge clk_fast);
      new_a = a;
      new_b = b;
      if ((a == b) == fwd) begin
         new_a = ~a;                                   // forward moves a when a equals b
      end else begin
         new_b = ~b;
      end
      model_dir = (new_a ^ b) ^ model_invert;
      model_pos = model_dir ? model_pos + 1 : model_pos - 1;
      a = new_a;
      b = new_b;
   endtask

   task automatic walk(input int first, input int count);
      for (int i = first; i < first + count; i++) begin
         encoder_step(forward[i]);
         wait_cycles(gaps[i] - 1);                     // edges exactly gaps[i] apart
      end
   endtask

   task automatic check_position(input string test, output logic [31:0] rd);
      wait_cycles(settle);
      bus_read(reg_position_addr, rd);
      check_value(test, model_pos, rd);
   endtask

   task automatic check_period(input string test, input logic [31:0] expected);
      logic [31:0] rd;
      wait_cycles(settle);
      bus_read(reg_period_addr, rd);
      check_value(test, expected, rd);
   endtask

   // ----------------------------------------
   // bus handshake monitor
   // ----------------------------------------

   always @(posedge clk_fast) begin
      check_value("bus_handshake", {31'd0, ack_expected}, {31'd0, wb_ack});
      ack_expected = reset & wb_cyc & wb_stb & ~wb_ack; // ack follows an unacked request
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------

   initial begin
      logic [31:0] rd;
      logic [31:0] preset;
      logic signed [31:0] walk_start;
      logic signed [31:0] walk_delta;
      period_word_t word;
      longint gap_total;

      reset        = 1'b1;
      a            = 1'b0;
      b            = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      model_pos    = 0;
      model_dir    = 1'b0;
      model_invert = 1'b0;
      rng_state    = 32'h93b7_1098;
      gap_total    = 0;
      for (int i = 0; i < num_steps; i++) begin
         rng_state  = lcg_next(rng_state);
         gaps[i]    = 3 + int'(rng_state[23:8] % 198); // 3 to 200 cycles
         forward[i] = rng_state[31];
         gap_total += gaps[i];
      end

      // walks, pauses, settles and bus traffic, doubled for margin
      watchdog_cycles = 2 * (2 * gap_total + long_pause + 8 * period_gap
                             + 4 * bus_op_limit + 20 * settle);
      fork
         begin
            #(watchdog_cycles * clk_period);
            stop_on_error("watchdog expired before the tests finished");
         end
      join_none

      #1 reset = 1'b0;
      repeat (5) @(negedge clk_fast);
      reset = 1'b1;
      check_value("reset_ack", 32'd0, {31'd0, wb_ack});
      wait_cycles(2);

      // ---- map and handshake ----
      bus_read(4'd8, rd);                              // aliases period if decode is short
      check_value("unmapped_read", 32'd0, rd);
      bus_write(4'd9, 32'hffff_ffff);                  // must be ignored
      bus_read(reg_ctrl_addr, rd);
      check_value("ctrl_after_reset", 32'd0, rd);
      check_position("position_after_reset", rd);

      // ---- position tracking, plain then inverted ----
      walk_start = model_pos;
      walk(0, walk_steps);
      check_position("position_walk", rd);
      walk_delta = model_pos - walk_start;
      bus_write(reg_ctrl_addr, 32'd1);
      model_invert = 1'b1;
      walk_start = model_pos;
      walk(0, walk_steps);
      check_position("position_inverted", rd);
      check_value("inverted_delta", walk_start - walk_delta, rd); // same steps, other way
      bus_write(reg_ctrl_addr, 32'd0);
      model_invert = 1'b0;

      // ---- preset ----
      rng_state = lcg_next(rng_state);
      preset    = rng_state;
      bus_write(reg_position_addr, preset);
      model_pos = preset;
      bus_read(reg_position_addr, rd);
      check_value("position_preset", preset, rd);
      walk(walk_steps, num_steps - walk_steps);
      check_position("position_after_preset", rd);

      // ---- period, steady direction ----
      encoder_step(1'b1);
      wait_cycles(period_gap - 1);
      encoder_step(1'b1);
      wait_cycles(period_gap - 1);
      encoder_step(1'b1);                              // latch now holds gap minus one
      check_period("period_latched", {1'b1, 1'b1, 1'b0, 7'd0, 22'(period_gap - 1)});
      wait_cycles(2 * period_gap);
      bus_read(reg_period_addr, rd);
      word.raw = rd;
      check_value("period_running_flag", 32'd0, {31'd0, word.fields.from_latch});
      assert (word.fields.count > period_gap - 1)
         else stop_on_error($sformatf("ERR period_running expected more than %0d actual %0d",
                                      period_gap - 1, word.fields.count));
      wait_cycles(long_pause);                         // counter runs into saturation
      check_period("period_saturated", {1'b0, 1'b1, 1'b0, 7'd0, period_overflow});

      // ---- direction change ----
      encoder_step(1'b0);
      check_period("period_reversal", {1'b0, 1'b0, 1'b1, 7'd0, period_overflow});
      wait_cycles(20);
      encoder_step(1'b0);                              // latch took the saturated count
      check_period("period_after_reversal", {1'b1, 1'b0, 1'b0, 7'd0, period_overflow});
      check_position("position_reversal", rd);

      // ---- illegal transition ----
      @(negedge clk_fast);
      a = ~a;                                          // both lines in one cycle
      b = ~b;
      wait_cycles(settle);
      bus_read(reg_status_addr, rd);
      check_value("illegal_status", 32'd1, rd);
      check_position("illegal_position", rd);          // model left alone
      bus_write(reg_status_addr, 32'd1);
      bus_read(reg_status_addr, rd);
      check_value("status_cleared", 32'd0, rd);
      encoder_step(1'b1);
      check_position("position_after_illegal", rd);

      wait_cycles(4);
      $display("NO ERRORS");
      $finish;
   end

endmodule
